//--- list.f
+incdir+design
design/bank_pkg.sv
design/bank_if.sv
design/sync_fifo.sv
design/bank_req_decode.sv
design/bank_sram.sv
design/bank_rd_return.sv
design/banked_mem_top.sv
tests/banked_mem_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= banked_mem_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash or the fail message in the log both fail the target.
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/banked_mem_tb.sv
`default_nettype none

`include "bank_macros.svh"

module banked_mem_tb;

  localparam int NUM_REQ  = 984;
  localparam int CLK_HALF = 5;
  // twenty cycles per request plus a margin.
  localparam int WATCHDOG = (NUM_REQ * 20 + 500) * 2 * CLK_HALF;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  logic                req_ready;
  logic                req_write;
  bank_pkg::bank_idx_t req_bank;
  bank_pkg::row_idx_t  req_row;
  bank_pkg::data_t     req_mask;
  bank_pkg::data_t     req_data;
  logic                rsp_valid;
  logic                rsp_ready;
  bank_pkg::data_t     rsp_data;

  logic [31:0]         rand_state;
  bank_pkg::data_t     model [`BANK_NUM * `BANK_ROWS];
  bank_pkg::data_t     exp_q [$];
  bank_pkg::mem_req_t  stim_q [$];
  bank_pkg::mem_req_t  cur_req;
  bank_pkg::row_idx_t  rows [`BANK_NUM];
  logic                taken;
  logic                saw_ready_low;
  int                  errors;
  int                  checks;
  int                  reads;
  int                  rsps;

  banked_mem_top i_banked_mem_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_bank  (req_bank),
    .req_row   (req_row),
    .req_mask  (req_mask),
    .req_data  (req_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  always #CLK_HALF clk = ~clk;

  // lcg, rotated so the better high bits land low.
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return (rand_state >> 16) | (rand_state << 16);
  endfunction

  function automatic bank_pkg::data_t fill_word(input int addr);
    return 32'h5a5a0000 ^ (32'(addr) * 32'h9e3779b1);
  endfunction

  task automatic push_req(input logic wr, input bank_pkg::bank_idx_t bank,
                          input bank_pkg::row_idx_t row, input bank_pkg::data_t mask,
                          input bank_pkg::data_t data);
    stim_q.push_back('{write: wr, bank: bank, row: row, mask: mask, data: data});
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // model side of an accepted request.
  task automatic apply_req(input bank_pkg::mem_req_t r);
    int addr;
    addr = int'(r.bank) * `BANK_ROWS + int'(r.row);
    if (r.write) begin
      for (int i = 0; i < `BANK_DATA_W; i++) begin
        if (r.mask[i]) model[addr][i] = r.data[i];
      end
    end else begin
      exp_q.push_back(model[addr]);
      reads++;
    end
  endtask

  task automatic step(input int ready_pct);
    logic            ready_seen;
    logic            valid_seen;
    bank_pkg::data_t data_seen;
    @(negedge clk);
    // outputs move only on the rising edge, so these are the values it will see.
    ready_seen = req_ready;
    valid_seen = rsp_valid;
    data_seen  = rsp_data;
    if (taken) begin
      req_valid = 1'b0;
      taken     = 1'b0;
    end
    rsp_ready = int'(next_rand() % 32'd100) < ready_pct;
    if (valid_seen && rsp_ready) begin
      rsps++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0t arrived with no read outstanding", $time);
      end else begin
        check_value("rsp_data", exp_q.pop_front(), data_seen);
      end
    end
    if (!req_valid && stim_q.size() > 0 && next_rand() % 32'd8 != 0) begin
      cur_req   = stim_q.pop_front();
      req_valid = 1'b1;
      req_write = cur_req.write;
      req_bank  = cur_req.bank;
      req_row   = cur_req.row;
      req_mask  = cur_req.mask;
      req_data  = cur_req.data;
    end
    if (req_valid && !ready_seen && exp_q.size() > 0) saw_ready_low = 1'b1;
    if (req_valid && ready_seen) begin
      apply_req(cur_req);
      taken = 1'b1;
    end
  endtask

  task automatic run_until_idle(input int ready_pct);
    while (stim_q.size() > 0 || (req_valid && !taken) || exp_q.size() > 0) begin
      step(ready_pct);
    end
  endtask

  initial begin
    bank_pkg::bank_idx_t lb;
    bank_pkg::row_idx_t  lr;
    clk = 1'b0;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_bank = '0;
    req_row = '0;
    req_mask = '0;
    req_data = '0;
    rsp_ready = 1'b0;
    rand_state = 32'd99;
    taken = 1'b0;
    saw_ready_low = 1'b0;
    errors = 0;
    checks = 0;
    reads = 0;
    rsps = 0;
    lb = '0;
    lr = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset: ready comes up, no response.
    for (int i = 0; i < 8 && !req_ready; i++) begin
      @(negedge clk);
      check_value("rsp_valid", 32'(0), 32'(rsp_valid));
    end
    check_value("req_ready", 32'(1), 32'(req_ready));

    for (int a = 0; a < `BANK_NUM * `BANK_ROWS; a++) begin
      push_req(1'b1, bank_pkg::bank_idx_t'(a / `BANK_ROWS),
               bank_pkg::row_idx_t'(a % `BANK_ROWS), '1, fill_word(a));
    end
    run_until_idle(100);

    // full-mask writes to every bank, then read back in order.
    for (int b = 0; b < `BANK_NUM; b++) begin
      rows[b] = bank_pkg::row_idx_t'(next_rand());
      push_req(1'b1, bank_pkg::bank_idx_t'(b), rows[b], '1, next_rand());
    end
    for (int b = 0; b < `BANK_NUM; b++) begin
      push_req(1'b0, bank_pkg::bank_idx_t'(b), rows[b], '0, '0);
    end
    run_until_idle(100);

    for (int i = 0; i < 16; i++) begin
      lb = bank_pkg::bank_idx_t'(next_rand());
      lr = bank_pkg::row_idx_t'(next_rand());
      push_req(1'b1, lb, lr, next_rand(), next_rand());
      push_req(1'b0, lb, lr, '0, '0);
    end
    run_until_idle(70);

    // stalled responses must back up into the request channel.
    saw_ready_low = 1'b0;
    for (int i = 0; i < 24; i++) begin
      push_req(1'b0, bank_pkg::bank_idx_t'(next_rand()),
               bank_pkg::row_idx_t'(next_rand()), '0, '0);
    end
    repeat (30) step(0);
    if (!saw_ready_low) begin
      errors++;
      $display("req_ready never dropped while responses were held back");
    end
    run_until_idle(40);

    for (int i = 0; i < 400; i++) begin
      if (next_rand() % 32'd4 != 0) begin
        lb = bank_pkg::bank_idx_t'(next_rand());
        lr = bank_pkg::row_idx_t'(next_rand());
      end
      push_req(next_rand() % 32'd2 == 1, lb, lr,
               (next_rand() % 32'd2 == 1) ? '1 : next_rand(), next_rand());
    end
    run_until_idle(60);

    // a few quiet cycles to catch a duplicated response.
    repeat (10) step(100);
    check_value("rsp_count", 32'(reads), 32'(rsps));
    $display("errors %0d checks %0d reads %0d responses %0d", errors, checks, reads, rsps);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("timeout: traffic still running after %0d time units", WATCHDOG);
    $display("errors %0d checks %0d", errors, checks);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/banked_mem_top.sv
`default_nettype none

`include "bank_macros.svh"

module banked_mem_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  logic                req_write,
  input  bank_pkg::bank_idx_t req_bank,
  input  bank_pkg::row_idx_t  req_row,
  input  bank_pkg::data_t     req_mask,
  input  bank_pkg::data_t     req_data,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output bank_pkg::data_t     rsp_data
);

  bank_pkg::mem_req_t  req;
  logic                rd_issue;
  bank_pkg::bank_idx_t rd_bank;
  logic                slot_free;

  bank_if bank_bus [`BANK_NUM] ();

  assign req = '{
    write: req_write,
    bank:  req_bank,
    row:   req_row,
    mask:  req_mask,
    data:  req_data
  };

  bank_req_decode i_req_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .banks     (bank_bus),
    .rd_issue  (rd_issue),
    .rd_bank   (rd_bank),
    .slot_free (slot_free)
  );

  for (genvar g = 0; g < `BANK_NUM; g++) begin : g_bank
    bank_sram i_bank_sram (
      .clk   (clk),
      .rst_n (rst_n),
      .port  (bank_bus[g])
    );
  end

  bank_rd_return i_rd_return (
    .clk       (clk),
    .rst_n     (rst_n),
    .banks     (bank_bus),
    .rd_issue  (rd_issue),
    .rd_bank   (rd_bank),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .slot_free (slot_free)
  );

endmodule

`default_nettype wire

//--- design/bank_rd_return.sv
`default_nettype none

`include "bank_macros.svh"

module bank_rd_return (
  input  logic                clk,
  input  logic                rst_n,
  bank_if.ret                 banks [`BANK_NUM],
  input  logic                rd_issue,
  input  bank_pkg::bank_idx_t rd_bank,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output bank_pkg::data_t     rsp_data,
  output logic                slot_free
);

  logic [`BANK_RD_DELAY-1:0] issue_vld;
  bank_pkg::bank_idx_t       issue_bank [`BANK_RD_DELAY];
  bank_pkg::data_t           bank_dout  [`BANK_NUM];
  bank_pkg::data_t           sel_data;
  logic                      push;
  logic                      rsp_in_ready;

  // flatten the bank outputs so they can be picked by index.
  for (genvar g = 0; g < `BANK_NUM; g++) begin : g_dout
    assign bank_dout[g] = banks[g].dout;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_vld <= '0;
    end else begin
      issue_vld[0] <= rd_issue;
      for (int i = 1; i < `BANK_RD_DELAY; i++) begin
        issue_vld[i] <= issue_vld[i-1];
      end
    end
  end

  // bank index follows the read through the bank latency.
  always_ff @(posedge clk) begin
    issue_bank[0] <= rd_bank;
    for (int i = 1; i < `BANK_RD_DELAY; i++) begin
      issue_bank[i] <= issue_bank[i-1];
    end
  end

  assign push     = issue_vld[`BANK_RD_DELAY-1];
  assign sel_data = bank_dout[issue_bank[`BANK_RD_DELAY-1]];

  sync_fifo #(
    .payload_t (bank_pkg::data_t),
    .DEPTH     (`BANK_RSP_DEPTH)
  ) i_rsp_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (push),
    .in_ready  (rsp_in_ready),
    .in_data   (sel_data),
    .out_valid (rsp_valid),
    .out_ready (rsp_ready),
    .out_data  (rsp_data)
  );

  assign slot_free = rsp_valid && rsp_ready;

  // credit limit upstream keeps room for every read in flight.
  a_push_room: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> rsp_in_ready);

endmodule

`default_nettype wire

//--- design/bank_sram.sv
`default_nettype none

`include "bank_macros.svh"

module bank_sram (
  input  logic clk,
  input  logic rst_n,
  bank_if.mem  port
);

  bank_pkg::data_t mem [`BANK_ROWS];

  // read pipeline, stage 0 holds the raw array word.
  bank_pkg::data_t rd_stage [`BANK_RD_DELAY];

  logic [`BANK_RD_DELAY-2:0] rd_vld;

  // masked write.
  always_ff @(posedge clk) begin
    if (port.wr) begin
      mem[port.row] <= (mem[port.row] & ~port.mask) | (port.din & port.mask);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld[0] <= port.rd;
      for (int i = 1; i < `BANK_RD_DELAY - 1; i++) begin
        rd_vld[i] <= rd_vld[i-1];
      end
    end
  end

  // each stage only moves with its read, so dout holds until the next one.
  always_ff @(posedge clk) begin
    if (port.rd) begin
      rd_stage[0] <= mem[port.row];
    end
    for (int i = 1; i < `BANK_RD_DELAY; i++) begin
      if (rd_vld[i-1]) begin
        rd_stage[i] <= rd_stage[i-1];
      end
    end
  end

  assign port.dout = rd_stage[`BANK_RD_DELAY-1];

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(port.rd && port.wr));

endmodule

`default_nettype wire

//--- design/bank_req_decode.sv
`default_nettype none

`include "bank_macros.svh"

module bank_req_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  output logic                req_ready,
  input  bank_pkg::mem_req_t  req,
  bank_if.ctrl                banks [`BANK_NUM],
  output logic                rd_issue,
  output bank_pkg::bank_idx_t rd_bank,
  input  logic                slot_free
);

  localparam int CNT_W = $clog2(`BANK_RSP_DEPTH + 1);

  bank_pkg::mem_req_t head;
  logic               head_valid;
  logic               head_pop;
  logic               issue_ok;
  logic               wr_issue;
  logic [CNT_W-1:0]   outstanding;

  sync_fifo #(
    .payload_t (bank_pkg::mem_req_t),
    .DEPTH     (`BANK_REQ_DEPTH)
  ) i_req_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (req),
    .out_valid (head_valid),
    .out_ready (head_pop),
    .out_data  (head)
  );

  // writes never need a response slot.
  assign issue_ok = head.write || (outstanding < CNT_W'(`BANK_RSP_DEPTH));
  assign head_pop = head_valid && issue_ok;

  assign rd_issue = head_pop && !head.write;
  assign wr_issue = head_pop && head.write;
  assign rd_bank  = head.bank;

  // reads in flight or waiting in the response queue.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      case ({rd_issue, slot_free})
        2'b10:   outstanding <= outstanding + CNT_W'(1);
        2'b01:   outstanding <= outstanding - CNT_W'(1);
        default: outstanding <= outstanding;
      endcase
    end
  end

  // one-hot strobes; row, mask and data go to every bank.
  for (genvar g = 0; g < `BANK_NUM; g++) begin : g_fan
    assign banks[g].rd   = rd_issue && (head.bank == bank_pkg::bank_idx_t'(g));
    assign banks[g].wr   = wr_issue && (head.bank == bank_pkg::bank_idx_t'(g));
    assign banks[g].row  = head.row;
    assign banks[g].mask = head.mask;
    assign banks[g].din  = head.data;
  end

  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= CNT_W'(`BANK_RSP_DEPTH));

  // a response can only leave for a read that was issued.
  a_no_spurious_free: assert property (@(posedge clk) disable iff (!rst_n)
    slot_free |-> outstanding != '0);

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`default_nettype none

`include "bank_macros.svh"

module sync_fifo #(
  parameter type payload_t = logic [`BANK_DATA_W-1:0],
  parameter int  DEPTH     = `BANK_REQ_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             ready_q;
  logic             push;
  logic             pop;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // ready is registered so it stays low through reset.
  assign in_ready  = ready_q;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_nxt = count;
    if (push && !pop) begin
      count_nxt = count + CNT_W'(1);
    end else if (pop && !push) begin
      count_nxt = count - CNT_W'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      ready_q <= 1'b0;
    end else begin
      count   <= count_nxt;
      ready_q <= (count_nxt != CNT_W'(DEPTH));
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH));

  // head word may not change while the consumer stalls.
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- design/bank_if.sv
`default_nettype none

`include "bank_macros.svh"

interface bank_if;

  // strobes, one bank at a time.
  logic rd;
  logic wr;

  bank_pkg::row_idx_t row;
  bank_pkg::data_t    mask;
  bank_pkg::data_t    din;

  // read data from the bank pipeline.
  bank_pkg::data_t    dout;

  modport ctrl (
    output rd,
    output wr,
    output row,
    output mask,
    output din
  );

  modport mem (
    input  rd,
    input  wr,
    input  row,
    input  mask,
    input  din,
    output dout
  );

  modport ret (
    input dout
  );

endinterface

`default_nettype wire

//--- design/bank_pkg.sv
`default_nettype none

`include "bank_macros.svh"

package bank_pkg;

  // one data word, also used as the per-bit write mask.
  typedef logic [`BANK_DATA_W-1:0] data_t;

  typedef logic [`BANK_BITS-1:0] bank_idx_t;

  typedef logic [`BANK_ROW_BITS-1:0] row_idx_t;

  // request record as it sits in the request queue.
  typedef struct packed {
    logic      write;
    bank_idx_t bank;
    row_idx_t  row;
    data_t     mask;
    data_t     data;
  } mem_req_t;

endpackage

`default_nettype wire

//--- design/bank_macros.svh
`ifndef BANK_MACROS_SVH
`define BANK_MACROS_SVH

// data word width.
`define BANK_DATA_W 32

// bank count, a power of two.
`define BANK_NUM 8
`define BANK_BITS 3

// rows in each bank.
`define BANK_ROWS 64
`define BANK_ROW_BITS 6

// bank read latency in cycles.
`define BANK_RD_DELAY 2

// queue depths; the response depth is also the read credit limit.
`define BANK_RSP_DEPTH 4
`define BANK_REQ_DEPTH 2

`endif
